//--- filelist.f
hw/ladder_pkg.sv
hw/ladder_prog_rom.sv
hw/ladder_ctrl.sv
hw/ladder_issue.sv
hw/mod_alu.sv
hw/ladder_top.sv
testbench/tb_clock_gen.sv
testbench/ladder_tb.sv

//--- hw/ladder_ctrl.sv
`timescale 1ns/1ns

module ladder_ctrl #(
    parameter int WIDTH       = 16,
    parameter int SCALAR_BITS = 8
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 cmd_valid_i,
    input  ladder_pkg::cmd_e                     cmd_i,
    input  logic [ladder_pkg::INSTR_W-1:0]       rom_instr_i,
    output logic [ladder_pkg::PROG_ADDR_W-1:0]   prog_addr_o,
    output logic [ladder_pkg::INSTR_W-1:0]       fetch_instr_o,
    output logic                                 fetch_valid_o,
    output logic                                 digit_req_o,
    output logic                                 ladder_active_o,
    output logic                                 busy_o
);

    localparam int STALL_W = $clog2(WIDTH + 1);
    localparam int STEP_W  = $clog2(SCALAR_BITS + 1);

    logic [ladder_pkg::PROG_ADDR_W-1:0] pc;
    logic [ladder_pkg::PROG_ADDR_W-1:0] fetch_addr_q;  // Address behind rom_instr_i
    logic                               valid_q;       // rom_instr_i is a fresh word
    logic                               stalled;
    logic [STALL_W-1:0]                 stall_cnt;
    logic [STEP_W-1:0]                  step_cnt;      // Ladder steps still to run
    logic                               busy_q;
    ladder_pkg::opcode_e                fetch_op;

    assign fetch_op    = ladder_pkg::opcode_e'(rom_instr_i[ladder_pkg::OPC_LSB +: 3]);
    assign prog_addr_o = pc;
    assign busy_o      = busy_q;

    // Bubbles go out as all-zero NOP words
    assign fetch_valid_o = valid_q;
    assign fetch_instr_o = valid_q ? rom_instr_i : '0;

    // Tags travel with the fetched word and the issue stage lines them up with the swap
    assign ladder_active_o = (fetch_addr_q >= ladder_pkg::STEP_S) &&
                             (fetch_addr_q <= ladder_pkg::STEP_E);
    assign digit_req_o     = valid_q && (fetch_addr_q == ladder_pkg::STEP_S);  // Once per step

    // --------------------
    // Sequencer FSM
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc           <= ladder_pkg::IDLE_S;
            fetch_addr_q <= ladder_pkg::IDLE_S;
            valid_q      <= 1'b0;
            stalled      <= 1'b0;
            stall_cnt    <= '0;
            step_cnt     <= '0;
            busy_q       <= 1'b0;
        end else begin
            fetch_addr_q <= pc;  // ROM registers the same address
            if (!busy_q) begin
                valid_q <= 1'b0;
                if (cmd_valid_i) begin
                    unique case (cmd_i)
                        ladder_pkg::CMD_MODMUL: begin
                            pc     <= ladder_pkg::MODMUL_S;
                            busy_q <= 1'b1;
                        end
                        ladder_pkg::CMD_MODEXP: begin
                            pc       <= ladder_pkg::MODEXP_INIT_S;
                            step_cnt <= STEP_W'(SCALAR_BITS);
                            busy_q   <= 1'b1;
                        end
                        default: ;  // NONE and reserved code are dropped
                    endcase
                end
            end else if (stalled) begin
                // PC held while the multiply runs
                if (stall_cnt != '0) begin
                    stall_cnt <= stall_cnt - 1'b1;
                end else begin
                    stalled <= 1'b0;  // Fetch restarts from the held PC next cycle
                end
            end else if (valid_q && fetch_op == ladder_pkg::OP_END) begin
                pc      <= ladder_pkg::IDLE_S;  // Back to idle
                busy_q  <= 1'b0;
                valid_q <= 1'b0;                // Drop the prefetched word
            end else if (valid_q && fetch_op == ladder_pkg::OP_MUL) begin
                stalled   <= 1'b1;              // WIDTH cycles of hold
                stall_cnt <= STALL_W'(WIDTH - 1);
                valid_q   <= 1'b0;
            end else begin
                valid_q <= 1'b1;
                if (pc == ladder_pkg::STEP_E) begin
                    step_cnt <= step_cnt - 1'b1;
                    pc       <= (step_cnt == STEP_W'(1)) ? ladder_pkg::FINAL_S
                                                         : ladder_pkg::STEP_S;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // A strobe while busy never makes the PC jump to an entry point
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (cmd_valid_i && busy_o) |=>
            (prog_addr_o == $past(prog_addr_o) + 1'b1) ||
            !(prog_addr_o == ladder_pkg::MODMUL_S ||
              prog_addr_o == ladder_pkg::MODEXP_INIT_S));

endmodule

//--- hw/ladder_issue.sv
`timescale 1ns/1ns

module ladder_issue #(
    parameter int SCALAR_BITS = 8
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             load_i,
    input  logic [SCALAR_BITS-1:0]           scalar_i,
    input  logic                             digit_req_i,
    input  logic                             ladder_active_i,
    input  logic [ladder_pkg::INSTR_W-1:0]   fetch_instr_i,
    input  logic                             fetch_valid_i,
    output logic [ladder_pkg::INSTR_W-1:0]   issue_instr_o,
    output logic                             issue_valid_o
);

    logic [ladder_pkg::INSTR_W-1:0] pipe1_instr;
    logic                           pipe1_valid;
    logic                           pipe1_active;  // Word belongs to a ladder step
    logic [SCALAR_BITS-1:0]         scalar_sr;     // MSB goes out first
    logic                           digit;
    logic [ladder_pkg::INSTR_W-1:0] swapped;

    // Flip R0/R1 only, other slots pass
    function automatic logic [ladder_pkg::REG_ADDR_W-1:0] swap_slot(
        input logic [ladder_pkg::REG_ADDR_W-1:0] slot,
        input logic                              bit_i
    );
        if (slot[2:1] == ladder_pkg::SWAP_TAG)
            return {slot[2:1], slot[0] ^ bit_i};
        return slot;
    endfunction

    // Same gates for both digit values, so timing does not leak the scalar
    always_comb begin
        swapped = pipe1_instr;
        if (pipe1_active) begin
            swapped[ladder_pkg::DST_LSB +: 3]  = swap_slot(pipe1_instr[ladder_pkg::DST_LSB +: 3], digit);
            swapped[ladder_pkg::SRCA_LSB +: 3] = swap_slot(pipe1_instr[ladder_pkg::SRCA_LSB +: 3], digit);
            swapped[ladder_pkg::SRCB_LSB +: 3] = swap_slot(pipe1_instr[ladder_pkg::SRCB_LSB +: 3], digit);
        end
    end

    // --------------------
    // Control and scalar
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pipe1_valid   <= 1'b0;
            pipe1_active  <= 1'b0;
            issue_valid_o <= 1'b0;
            scalar_sr     <= '0;
            digit         <= 1'b0;
        end else begin
            pipe1_valid   <= fetch_valid_i;
            pipe1_active  <= ladder_active_i;
            issue_valid_o <= pipe1_valid;
            if (load_i) begin
                scalar_sr <= scalar_i;
            end else if (digit_req_i) begin
                digit     <= scalar_sr[SCALAR_BITS-1];  // Next bit for this step
                scalar_sr <= scalar_sr << 1;
            end
        end
    end

    // Instruction payload
    always_ff @(posedge clk) begin
        pipe1_instr   <= fetch_instr_i;
        issue_instr_o <= swapped;
    end

    a_digit_in_ladder: assert property (@(posedge clk) disable iff (!reset_n)
        digit_req_i |-> ladder_active_i);

endmodule

//--- hw/ladder_pkg.sv
package ladder_pkg;

    // --------------------
    // Instruction format
    // --------------------
    localparam int REG_ADDR_W  = 3;                  // 8 register slots
    localparam int OPC_W       = 3;
    localparam int INSTR_W     = OPC_W + 3 * REG_ADDR_W;  // 12 bits
    localparam int OPC_LSB     = 9;                  // [11:9] opcode
    localparam int DST_LSB     = 6;                  // [8:6] destination
    localparam int SRCA_LSB    = 3;                  // [5:3] first source
    localparam int SRCB_LSB    = 0;                  // [2:0] second source
    localparam int PROG_ADDR_W = 5;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP = 3'd0,  // Bubble
        OP_LDA = 3'd1,  // dst <= captured A
        OP_LDB = 3'd2,  // dst <= captured B
        OP_LD1 = 3'd3,  // dst <= 1
        OP_MOV = 3'd4,  // dst <= srca
        OP_MUL = 3'd5,  // dst <= srca * srcb mod M
        OP_OUT = 3'd6,  // result <= srca
        OP_END = 3'd7   // Program finished
    } opcode_e;

    // Command codes, 2'b11 is reserved
    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_MODMUL = 2'd1,
        CMD_MODEXP = 2'd2
    } cmd_e;

    // --------------------
    // Microprogram layout
    // --------------------
    localparam logic [PROG_ADDR_W-1:0] IDLE_S        = 5'd0;   // Parked here when idle
    localparam logic [PROG_ADDR_W-1:0] MODMUL_S      = 5'd1;
    localparam logic [PROG_ADDR_W-1:0] MODEXP_INIT_S = 5'd6;
    localparam logic [PROG_ADDR_W-1:0] STEP_S        = 5'd8;   // First op of a ladder step
    localparam logic [PROG_ADDR_W-1:0] STEP_E        = 5'd10;  // Last op of a ladder step
    localparam logic [PROG_ADDR_W-1:0] FINAL_S       = 5'd11;

    // --------------------
    // Ladder slots
    // --------------------
    // R0 and R1 differ only in bit 0, so the swap is a single XOR
    localparam logic [REG_ADDR_W-1:0] SLOT_R0  = 3'd2;
    localparam logic [REG_ADDR_W-1:0] SLOT_R1  = 3'd3;
    localparam logic [REG_ADDR_W-1:0] SLOT_T   = 3'd4;
    localparam logic [1:0]            SWAP_TAG = 2'b01;  // Upper bits of a swappable slot

endpackage

//--- hw/ladder_prog_rom.sv
`timescale 1ns/1ns

module ladder_prog_rom (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic [ladder_pkg::PROG_ADDR_W-1:0]   addr_i,
    output logic [ladder_pkg::INSTR_W-1:0]       instr_o
);

    logic [ladder_pkg::INSTR_W-1:0] rom_word;  // Combinational table output

    // Word layout is {opcode, dst, srca, srcb}
    always_comb begin
        unique case (addr_i)
            // MODMUL, slot 5 holds the product
            5'd1:  rom_word = {ladder_pkg::OP_LDA, 3'd0, 3'd0, 3'd0};
            5'd2:  rom_word = {ladder_pkg::OP_LDB, 3'd1, 3'd0, 3'd0};
            5'd3:  rom_word = {ladder_pkg::OP_MUL, 3'd5, 3'd0, 3'd1};
            5'd4:  rom_word = {ladder_pkg::OP_OUT, 3'd0, 3'd5, 3'd0};
            5'd5:  rom_word = {ladder_pkg::OP_END, 3'd0, 3'd0, 3'd0};
            // MODEXP init, R0 = 1 and R1 = base
            5'd6:  rom_word = {ladder_pkg::OP_LD1, ladder_pkg::SLOT_R0, 3'd0, 3'd0};
            5'd7:  rom_word = {ladder_pkg::OP_LDA, ladder_pkg::SLOT_R1, 3'd0, 3'd0};
            // Ladder step, written for bit 0 and swapped in flight for bit 1
            5'd8:  rom_word = {ladder_pkg::OP_MUL, ladder_pkg::SLOT_T,
                               ladder_pkg::SLOT_R0, ladder_pkg::SLOT_R1};  // T = R0*R1
            5'd9:  rom_word = {ladder_pkg::OP_MUL, ladder_pkg::SLOT_R0,
                               ladder_pkg::SLOT_R0, ladder_pkg::SLOT_R0};  // R0 = R0^2
            5'd10: rom_word = {ladder_pkg::OP_MOV, ladder_pkg::SLOT_R1,
                               ladder_pkg::SLOT_T, 3'd0};                  // R1 = T
            // Final part
            5'd11: rom_word = {ladder_pkg::OP_OUT, 3'd0, ladder_pkg::SLOT_R0, 3'd0};
            5'd12: rom_word = {ladder_pkg::OP_END, 3'd0, 3'd0, 3'd0};
            default: rom_word = {ladder_pkg::OP_NOP, 3'd0, 3'd0, 3'd0};  // Idle and unused
        endcase
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= '0;  // NOP
        end else begin
            instr_o <= rom_word;
        end
    end

endmodule

//--- hw/ladder_top.sv
`timescale 1ns/1ns

module ladder_top #(
    parameter int WIDTH       = 16,
    parameter int MODULUS     = 65521,
    parameter int SCALAR_BITS = 8
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               cmd_valid_i,
    input  ladder_pkg::cmd_e   cmd_i,
    input  logic [WIDTH-1:0]   operand_a_i,
    input  logic [WIDTH-1:0]   operand_b_i,
    output logic [WIDTH-1:0]   result_o,
    output logic               done_o,
    output logic               busy_o
);

    // --------------------
    // Stage wiring
    // --------------------
    logic [ladder_pkg::PROG_ADDR_W-1:0] prog_addr;
    logic [ladder_pkg::INSTR_W-1:0]     rom_instr, fetch_instr, issue_instr;
    logic                               fetch_valid, issue_valid;
    logic                               digit_req, ladder_active;

    ladder_prog_rom i_rom (
        .clk(clk), .reset_n(reset_n), .addr_i(prog_addr), .instr_o(rom_instr)
    );

    ladder_ctrl #(.WIDTH(WIDTH), .SCALAR_BITS(SCALAR_BITS)) i_ctrl (
        .clk(clk), .reset_n(reset_n), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
        .rom_instr_i(rom_instr), .prog_addr_o(prog_addr), .fetch_instr_o(fetch_instr),
        .fetch_valid_o(fetch_valid), .digit_req_o(digit_req),
        .ladder_active_o(ladder_active), .busy_o(busy_o)
    );

    // Accept strobe is any command while idle
    ladder_issue #(.SCALAR_BITS(SCALAR_BITS)) i_issue (
        .clk(clk), .reset_n(reset_n), .load_i(cmd_valid_i & ~busy_o),
        .scalar_i(operand_b_i[SCALAR_BITS-1:0]), .digit_req_i(digit_req),
        .ladder_active_i(ladder_active), .fetch_instr_i(fetch_instr),
        .fetch_valid_i(fetch_valid), .issue_instr_o(issue_instr), .issue_valid_o(issue_valid)
    );

    mod_alu #(.WIDTH(WIDTH), .MODULUS(MODULUS)) i_alu (
        .clk(clk), .reset_n(reset_n), .load_i(cmd_valid_i & ~busy_o),
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i),
        .issue_instr_i(issue_instr), .issue_valid_i(issue_valid),
        .result_o(result_o), .done_o(done_o)
    );

endmodule

//--- hw/mod_alu.sv
`timescale 1ns/1ns

module mod_alu #(
    parameter int WIDTH   = 16,
    parameter int MODULUS = 65521
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             load_i,
    input  logic [WIDTH-1:0]                 operand_a_i,
    input  logic [WIDTH-1:0]                 operand_b_i,
    input  logic [ladder_pkg::INSTR_W-1:0]   issue_instr_i,
    input  logic                             issue_valid_i,
    output logic [WIDTH-1:0]                 result_o,
    output logic                             done_o
);

    localparam int               CNT_W   = $clog2(WIDTH + 1);
    localparam logic [WIDTH:0]   MOD_EXT = (WIDTH + 1)'(MODULUS);

    logic [WIDTH-1:0]  rf [8];         // Operand register file
    logic [WIDTH-1:0]  a_q, b_q;       // Captured operands, already reduced
    ladder_pkg::opcode_e op;
    logic [2:0]        dst, srca, srcb;
    logic              mul_busy;
    logic [CNT_W-1:0]  mul_cnt;
    logic [WIDTH-1:0]  acc, mcand, mplier;
    logic [2:0]        mul_dst;
    logic [WIDTH:0]    dbl, dbl_r, sum;
    logic [WIDTH-1:0]  acc_next;

    assign op   = ladder_pkg::opcode_e'(issue_instr_i[ladder_pkg::OPC_LSB +: 3]);
    assign dst  = issue_instr_i[ladder_pkg::DST_LSB +: 3];
    assign srca = issue_instr_i[ladder_pkg::SRCA_LSB +: 3];
    assign srcb = issue_instr_i[ladder_pkg::SRCB_LSB +: 3];

    // One subtract reduces a raw operand when MODULUS sits in the top half
    function automatic logic [WIDTH-1:0] reduce(input logic [WIDTH-1:0] x);
        return (x >= WIDTH'(MODULUS)) ? x - WIDTH'(MODULUS) : x;
    endfunction

    // --------------------
    // Shift-add step
    // --------------------
    always_comb begin
        dbl      = {acc, 1'b0};                                   // 2*acc
        dbl_r    = (dbl >= MOD_EXT) ? dbl - MOD_EXT : dbl;
        sum      = dbl_r + (mplier[WIDTH-1] ? {1'b0, mcand} : '0);  // Add on multiplier MSB
        acc_next = WIDTH'((sum >= MOD_EXT) ? sum - MOD_EXT : sum);
    end

    // Control state
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_busy <= 1'b0;
            mul_cnt  <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= issue_valid_i && op == ladder_pkg::OP_OUT;  // One cycle strobe
            if (issue_valid_i && op == ladder_pkg::OP_MUL) begin
                mul_busy <= 1'b1;
                mul_cnt  <= CNT_W'(WIDTH);
            end else if (mul_busy) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == CNT_W'(1))
                    mul_busy <= 1'b0;  // Last bit done this cycle
            end
        end
    end

    // Register file and datapath
    always_ff @(posedge clk) begin
        if (load_i) begin
            a_q <= reduce(operand_a_i);
            b_q <= reduce(operand_b_i);
        end
        if (mul_busy) begin
            acc    <= acc_next;
            mplier <= mplier << 1;
            if (mul_cnt == CNT_W'(1))
                rf[mul_dst] <= acc_next;  // Write back
        end
        if (issue_valid_i) begin
            unique case (op)
                ladder_pkg::OP_LDA: rf[dst] <= a_q;
                ladder_pkg::OP_LDB: rf[dst] <= b_q;
                ladder_pkg::OP_LD1: rf[dst] <= WIDTH'(1);
                ladder_pkg::OP_MOV: rf[dst] <= rf[srca];
                ladder_pkg::OP_MUL: begin
                    acc     <= '0;
                    mcand   <= rf[srca];
                    mplier  <= rf[srcb];
                    mul_dst <= dst;
                end
                ladder_pkg::OP_OUT: result_o <= rf[srca];
                default: ;  // NOP and END
            endcase
        end
    end

    // Controller stall must cover the full multiply
    a_mul_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        (issue_valid_i && op == ladder_pkg::OP_MUL) |-> !mul_busy);

endmodule

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of ladder_tb, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ladder_tb \
    -f filelist.f -o ladder_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/ladder_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench passed" sim.log && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }

//--- testbench/ladder_tb.sv
`timescale 1ns/1ns

module ladder_tb;

    localparam int WIDTH       = 16;
    localparam int MODULUS     = 65521;
    localparam int SCALAR_BITS = 8;
    localparam int DRIVE_DLY   = 10;    // Skew after the rising edge
    localparam int DONE_LIMIT  = 2000;  // Cycles allowed per command
    localparam int QUIET_LEN   = 100;   // Window with no done expected
    localparam int NUM_ROWS    = 14;

    logic             clk, reset_n;
    logic             cmd_valid;
    ladder_pkg::cmd_e cmd;
    logic [WIDTH-1:0] operand_a, operand_b, result;
    logic             done, busy;
    int               errors;
    int               timeouts;

    // Stimulus table, expected column filled from the reference model
    ladder_pkg::cmd_e tbl_cmd [NUM_ROWS];
    logic [WIDTH-1:0] tbl_a   [NUM_ROWS];
    logic [WIDTH-1:0] tbl_b   [NUM_ROWS];
    logic [WIDTH-1:0] tbl_exp [NUM_ROWS];

    tb_clock_gen i_clk_gen (.clk(clk), .reset_n(reset_n));

    ladder_top #(.WIDTH(WIDTH), .MODULUS(MODULUS), .SCALAR_BITS(SCALAR_BITS)) i_dut (
        .clk(clk), .reset_n(reset_n), .cmd_valid_i(cmd_valid), .cmd_i(cmd),
        .operand_a_i(operand_a), .operand_b_i(operand_b),
        .result_o(result), .done_o(done), .busy_o(busy)
    );

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [WIDTH-1:0] ref_model(input ladder_pkg::cmd_e c,
                                                   input logic [WIDTH-1:0] a,
                                                   input logic [WIDTH-1:0] b);
        longint unsigned        base;
        longint unsigned        acc;
        logic [SCALAR_BITS-1:0] k;
        base = a % MODULUS;
        if (c == ladder_pkg::CMD_MODMUL)
            return WIDTH'((base * (b % MODULUS)) % MODULUS);
        acc = 1;
        k   = b[SCALAR_BITS-1:0];  // Only the low bits reach the scalar register
        for (int i = SCALAR_BITS - 1; i >= 0; i--) begin
            acc = (acc * acc) % MODULUS;            // Square
            if (k[i])
                acc = (acc * base) % MODULUS;       // Multiply on a one bit
        end
        return WIDTH'(acc);
    endfunction

    task automatic set_row(input int idx, input ladder_pkg::cmd_e c,
                           input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
        tbl_cmd[idx] = c;
        tbl_a[idx]   = a;
        tbl_b[idx]   = b;
        tbl_exp[idx] = ref_model(c, a, b);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // --------------------
    // Drive and wait
    // --------------------
    task automatic send_cmd(input ladder_pkg::cmd_e c, input logic [WIDTH-1:0] a,
                            input logic [WIDTH-1:0] b);
        @(posedge clk);
        #DRIVE_DLY;
        cmd_valid = 1'b1;
        cmd       = c;
        operand_a = a;
        operand_b = b;
        @(posedge clk);  // Accept edge
        #DRIVE_DLY;
        cmd_valid = 1'b0;
    endtask

    // Cycles counted from the accept edge
    task automatic wait_done(input string what, output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < DONE_LIMIT) begin
            if (done === 1'b1) begin
                ok = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DLY;
                cycles++;
            end
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout at %0t ns: done never came for %s", $time, what);
        end
    endtask

    task automatic run_cmd(input ladder_pkg::cmd_e c, input logic [WIDTH-1:0] a,
                           input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] expected,
                           input string what, output int cycles, output bit ok);
        send_cmd(c, a, b);
        wait_done(what, cycles, ok);
        if (ok) begin
            check_value(result, expected, what);
            @(posedge clk);
            #DRIVE_DLY;
            check_value(done, 0, {what, ": done longer than one cycle"});
            check_value(busy, 0, {what, ": busy after done"});
        end
    endtask

    // Counts done pulses and busy cycles over a quiet window
    task automatic watch_quiet(output int pulses, output int busy_cycles);
        pulses      = 0;
        busy_cycles = 0;
        repeat (QUIET_LEN) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (done === 1'b1) pulses++;
            if (busy !== 1'b0) busy_cycles++;
        end
    endtask

    initial begin
        logic [WIDTH-1:0] a, b;
        int               cycles, cyc_lo, cyc_hi, pulses, busy_cycles, n;
        bit               ok, ok_lo, ok_hi;
        cmd_valid = 1'b0;  // All DUT inputs idle from time zero
        cmd       = ladder_pkg::CMD_NONE;
        operand_a = '0;
        operand_b = '0;
        errors    = 0;
        timeouts  = 0;
        a         = WIDTH'($urandom(14504));  // Single seed for the run
        set_row(0,  ladder_pkg::CMD_MODMUL, 16'd0,     16'd1234);
        set_row(1,  ladder_pkg::CMD_MODMUL, 16'd1,     16'd4321);
        set_row(2,  ladder_pkg::CMD_MODMUL, 16'd65520, 16'd65520);
        set_row(3,  ladder_pkg::CMD_MODMUL, 16'd65520, 16'd1);
        set_row(4,  ladder_pkg::CMD_MODMUL, 16'd12345, 16'd54321);
        set_row(5,  ladder_pkg::CMD_MODMUL, 16'd65535, 16'd2);      // Raw A above modulus
        set_row(6,  ladder_pkg::CMD_MODEXP, 16'd3,     16'd0);      // k = 0 gives one
        set_row(7,  ladder_pkg::CMD_MODEXP, 16'd3,     16'h00ff);   // All ones scalar
        set_row(8,  ladder_pkg::CMD_MODEXP, 16'd0,     16'd5);
        set_row(9,  ladder_pkg::CMD_MODEXP, 16'd1,     16'h00ff);
        set_row(10, ladder_pkg::CMD_MODEXP, 16'd2,     16'd16);     // Wraps past 2^16
        set_row(11, ladder_pkg::CMD_MODEXP, 16'd65520, 16'd3);
        set_row(12, ladder_pkg::CMD_MODEXP, 16'd12345, 16'h00a5);
        set_row(13, ladder_pkg::CMD_MODEXP, 16'd0,     16'd0);

        n = 0;
        while (reset_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset_n !== 1'b1) begin
            timeouts++;
            $display("Reset was never released");
        end
        check_value(busy, 0, "busy after reset");
        check_value(done, 0, "done after reset");

        // --------------------
        // Table and random rows
        // --------------------
        for (int i = 0; i < NUM_ROWS; i++)
            run_cmd(tbl_cmd[i], tbl_a[i], tbl_b[i], tbl_exp[i], $sformatf("row %0d", i),
                    cycles, ok);
        for (int i = 0; i < 20; i++) begin
            a = WIDTH'($urandom);
            b = WIDTH'($urandom);
            run_cmd(ladder_pkg::CMD_MODMUL, a, b, ref_model(ladder_pkg::CMD_MODMUL, a, b),
                    $sformatf("random MODMUL %0d", i), cycles, ok);
            run_cmd(ladder_pkg::CMD_MODEXP, a, b, ref_model(ladder_pkg::CMD_MODEXP, a, b),
                    $sformatf("random MODEXP %0d", i), cycles, ok);
        end

        // Strobe while busy is dropped
        send_cmd(ladder_pkg::CMD_MODMUL, 16'd1234, 16'd567);
        check_value(busy, 1, "busy after accept");
        send_cmd(ladder_pkg::CMD_MODEXP, 16'd999, 16'h00ff);
        wait_done("first of two commands", cycles, ok);
        if (ok) begin
            check_value(result, ref_model(ladder_pkg::CMD_MODMUL, 16'd1234, 16'd567),
                        "result of first command");
            watch_quiet(pulses, busy_cycles);
            check_value(pulses, 0, "extra done after ignored command");
        end

        // No program for NONE and the reserved code
        send_cmd(ladder_pkg::CMD_NONE, 16'd5, 16'd5);
        watch_quiet(pulses, busy_cycles);
        check_value(pulses, 0, "done after CMD_NONE");
        check_value(busy_cycles, 0, "busy after CMD_NONE");
        send_cmd(ladder_pkg::cmd_e'(2'b11), 16'd5, 16'd5);
        watch_quiet(pulses, busy_cycles);
        check_value(pulses, 0, "done after reserved command");
        check_value(busy_cycles, 0, "busy after reserved command");

        // Same latency for a sparse and a dense scalar
        run_cmd(ladder_pkg::CMD_MODEXP, 16'd7, 16'h0001,
                ref_model(ladder_pkg::CMD_MODEXP, 16'd7, 16'h0001), "MODEXP sparse k",
                cyc_lo, ok_lo);
        run_cmd(ladder_pkg::CMD_MODEXP, 16'd7, 16'h00fe,
                ref_model(ladder_pkg::CMD_MODEXP, 16'd7, 16'h00fe), "MODEXP dense k",
                cyc_hi, ok_hi);
        if (ok_lo && ok_hi)
            check_value(cyc_hi, cyc_lo, "MODEXP latency depends on scalar");

        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 100,  // ns
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held low for the first rising edges, released with the input skew
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset_n = 1'b1;
    end

endmodule
